// File: decode_ctrl.f
+incdir+testbench
design/decode_ctrl_pkg.sv
design/uop_packer.sv
design/dispatch_ctrl.sv
design/decode_ctrl.sv
testbench/decode_ctrl_tb.sv

// File: design/decode_ctrl.sv
`timescale 1ns/100ps

module decode_ctrl (
  input  logic                                                        clk,
  input  logic                                                        arst_n,
  input  decode_ctrl_pkg::de_slot_t [decode_ctrl_pkg::num_de_inst-1:0] slots,
  input  logic [decode_ctrl_pkg::num_de_uop-1:0]                       almost_full,
  output logic [decode_ctrl_pkg::num_de_inst-1:0]                      pop,
  output logic [decode_ctrl_pkg::num_de_uop-1:0]                       push,
  output decode_ctrl_pkg::uop_t [decode_ctrl_pkg::num_de_uop-1:0]      dataout,
  output logic [decode_ctrl_pkg::uop_index_width-1:0]                  uop_index_remain
);

  import decode_ctrl_pkg::*;

  logic [num_de_inst-1:0] pkg_valid;
  logic [num_de_uop-1:0]  merged_valid;
  pack_status_t           status;

  // package valid travels inside each slot
  always_comb begin
    for (int s = 0; s < num_de_inst; s++) begin
      pkg_valid[s] = slots[s].pkg_valid;
    end
  end

  uop_packer packer (
    .slots        (slots),
    .merged_valid (merged_valid),
    .dataout      (dataout),
    .status       (status)
  );

  dispatch_ctrl dispatch (
    .clk              (clk),
    .arst_n           (arst_n),
    .pkg_valid        (pkg_valid),
    .merged_valid     (merged_valid),
    .status           (status),
    .almost_full      (almost_full),
    .push             (push),
    .pop              (pop),
    .uop_index_remain (uop_index_remain)
  );

endmodule

// File: design/decode_ctrl_pkg.sv
package decode_ctrl_pkg;

  // two decoded instructions per cycle
  localparam int num_de_inst       = 2;

  // uops per instruction slot, also the number of uop queue lanes
  localparam int num_de_uop        = 4;

  localparam int uop_index_width   = 3;

  // payload is opaque to dispatch
  localparam int uop_payload_width = 32;

  // one uop as it is written into the uop queue
  typedef struct packed {
    logic [uop_index_width-1:0]   uop_index;
    // final uop of its instruction
    logic                         last_uop_valid;
    logic [uop_payload_width-1:0] payload;
  } uop_t;

  // one decoded instruction slot from the decode unit
  typedef struct packed {
    logic                  pkg_valid;
    // fills from lane 0 upward
    logic [num_de_uop-1:0] uop_valid;
    uop_t [num_de_uop-1:0] uop;
  } de_slot_t;

  // packer result for one slot
  typedef struct packed {
    logic                       slot_empty;
    // final uop of the instruction lands in the lanes this cycle
    logic                       last_fit;
    // next uop to dispatch when the instruction does not finish
    logic [uop_index_width-1:0] resume_index;
  } slot_status_t;

  typedef struct packed {
    slot_status_t [num_de_inst-1:0] slot;
  } pack_status_t;

endpackage

// File: design/dispatch_ctrl.sv
`timescale 1ns/100ps

module dispatch_ctrl (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic [decode_ctrl_pkg::num_de_inst-1:0]     pkg_valid,
  input  logic [decode_ctrl_pkg::num_de_uop-1:0]      merged_valid,
  input  decode_ctrl_pkg::pack_status_t               status,
  input  logic [decode_ctrl_pkg::num_de_uop-1:0]      almost_full,
  output logic [decode_ctrl_pkg::num_de_uop-1:0]      push,
  output logic [decode_ctrl_pkg::num_de_inst-1:0]     pop,
  output logic [decode_ctrl_pkg::uop_index_width-1:0] uop_index_remain
);

  import decode_ctrl_pkg::*;

  logic                   queue_ready;
  logic [num_de_inst-1:0] slot_done;
  logic                   index_clear;
  logic                   index_load0;
  logic                   index_load1;

  // every lane in use needs room, and there must be something to push
  assign queue_ready = (|merged_valid) && ((merged_valid & almost_full) == '0);

  assign push = merged_valid & {num_de_uop{queue_ready}};

  // slot retires when it is empty or its final uop goes out now
  always_comb begin
    for (int s = 0; s < num_de_inst; s++) begin
      slot_done[s] = status.slot[s].slot_empty |
                     (status.slot[s].last_fit & queue_ready);
    end
  end

  // slot 1 only pops behind slot 0
  assign pop[0] = pkg_valid[0] & slot_done[0];
  assign pop[1] = pop[0] & pkg_valid[1] & slot_done[1];

  // whole command queue head retired
  assign index_clear = (pop[0] & ~pkg_valid[1]) | pop[1];

  // remember where a partly dispatched instruction restarts
  assign index_load0 = pkg_valid[0] &
                       ~status.slot[0].slot_empty &
                       ~status.slot[0].last_fit &
                       queue_ready;

  assign index_load1 = pkg_valid[1] &
                       ~status.slot[1].slot_empty &
                       ~status.slot[1].last_fit &
                       queue_ready &
                       pop[0];

  // clear wins over load
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      uop_index_remain <= '0;
    end else if (index_clear) begin
      uop_index_remain <= '0;
    end else if (index_load0) begin
      uop_index_remain <= status.slot[0].resume_index;
    end else if (index_load1) begin
      uop_index_remain <= status.slot[1].resume_index;
    end
  end

  a_no_push_when_full : assert property (
    @(posedge clk) disable iff (!arst_n)
    ((merged_valid & almost_full) != '0) |-> (push == '0)
  ) else begin
    $error("[ERROR] push = 0x%0h with almost_full = 0x%0h merged_valid = 0x%0h",
           push, almost_full, merged_valid);
  end

endmodule

// File: design/uop_packer.sv
`timescale 1ns/100ps

module uop_packer (
  input  decode_ctrl_pkg::de_slot_t [decode_ctrl_pkg::num_de_inst-1:0] slots,
  output logic [decode_ctrl_pkg::num_de_uop-1:0]                       merged_valid,
  output decode_ctrl_pkg::uop_t [decode_ctrl_pkg::num_de_uop-1:0]      dataout,
  output decode_ctrl_pkg::pack_status_t                                status
);

  import decode_ctrl_pkg::*;

  // one-hot occupancy of slot 0
  // bit k set when exactly lanes 0 to k-1 are valid
  // all zero if not contiguous
  logic [num_de_uop:0]        occ0;

  // slot 1 last flag seen among uops 0 to j
  logic [num_de_uop-1:0]      slot1_last_upto;

  logic                       slot0_last_fit;
  logic                       slot1_last_fit;
  logic [uop_index_width-1:0] slot0_resume;
  logic [uop_index_width-1:0] slot1_resume;

  // occupancy decode shared by placement and status
  always_comb begin
    for (int k = 0; k <= num_de_uop; k++) begin
      occ0[k] = (slots[0].uop_valid == num_de_uop'((1 << k) - 1));
    end
  end

  // running OR of slot 1 last flags from uop 0 upward
  always_comb begin
    slot1_last_upto[0] = slots[1].uop[0].last_uop_valid;
    for (int j = 1; j < num_de_uop; j++) begin
      slot1_last_upto[j] = slot1_last_upto[j-1] | slots[1].uop[j].last_uop_valid;
    end
  end

  // lane placement
  // slot 0 takes lanes below its count and slot 1 fills the rest from its uop 0
  always_comb begin
    merged_valid = '0;
    dataout      = '0;
    for (int k = 0; k <= num_de_uop; k++) begin
      if (occ0[k]) begin
        for (int l = 0; l < num_de_uop; l++) begin
          if (l < k) begin
            merged_valid[l] = slots[0].uop_valid[l];
            dataout[l]      = slots[0].uop[l];
          end else begin
            merged_valid[l] = slots[1].uop_valid[l-k];
            dataout[l]      = slots[1].uop_valid[l-k] ? slots[1].uop[l-k] : '0;
          end
        end
      end
    end
  end

  // final-uop and resume status
  // slot 1 only sees its uops 0 to 3-c, and nothing when slot 0 is full
  always_comb begin
    slot0_last_fit = 1'b0;
    slot1_last_fit = 1'b0;
    slot1_resume   = '0;
    for (int k = 0; k < num_de_uop; k++) begin
      if (occ0[k]) begin
        slot0_last_fit = (k != 0);
        slot1_last_fit = slot1_last_upto[num_de_uop-1-k];
        slot1_resume   = slots[1].uop[num_de_uop-1-k].uop_index + uop_index_width'(1);
      end
    end
    // full slot 0 only finishes if its top uop is the last one
    if (occ0[num_de_uop]) begin
      slot0_last_fit = slots[0].uop[num_de_uop-1].last_uop_valid;
    end
  end

  // slot 0 resumes after its top lane
  assign slot0_resume = slots[0].uop[num_de_uop-1].uop_index + uop_index_width'(1);

  always_comb begin
    for (int s = 0; s < num_de_inst; s++) begin
      status.slot[s].slot_empty = ~|slots[s].uop_valid;
    end
    status.slot[0].last_fit     = slot0_last_fit;
    status.slot[0].resume_index = slot0_resume;
    status.slot[1].last_fit     = slot1_last_fit;
    status.slot[1].resume_index = slot1_resume;
  end

  // decode side must hand over valid bits packed from lane 0
  always_comb begin
    for (int s = 0; s < num_de_inst; s++) begin
      a_uop_valid_contiguous : assert (
        (slots[s].uop_valid & (slots[s].uop_valid + 1'b1)) == '0
      ) else begin
        $error("[ERROR] slots[%0d].uop_valid not contiguous: 0x%0h",
               s, slots[s].uop_valid);
      end
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the decode_ctrl testbench with Verilator
# the log decides the result

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module decode_ctrl_tb -f decode_ctrl.f -o decode_ctrl_sim \
  && ./obj_dir/decode_ctrl_sim | tee sim.log

grep -qx "STATUS: PASS" sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// File: testbench/decode_ctrl_model.svh
`ifndef DECODE_CTRL_MODEL_SVH
`define DECODE_CTRL_MODEL_SVH

// number of valid uops in one slot
function automatic int uop_count(de_slot_t s);
  int n;
  n = 0;
  for (int i = 0; i < num_de_uop; i++) begin
    if (s.uop_valid[i]) begin
      n++;
    end
  end
  return n;
endfunction

// lane valid bits after slot 1 is appended behind slot 0
function automatic logic [num_de_uop-1:0] packed_valid(de_slot_t [num_de_inst-1:0] s);
  int c;
  logic [num_de_uop-1:0] v;
  c = uop_count(s[0]);
  v = '0;
  for (int l = 0; l < num_de_uop; l++) begin
    if (l < c) begin
      v[l] = 1'b1;
    end else begin
      v[l] = s[1].uop_valid[l-c];
    end
  end
  return v;
endfunction

function automatic uop_t [num_de_uop-1:0] packed_data(de_slot_t [num_de_inst-1:0] s);
  int c;
  uop_t [num_de_uop-1:0] d;
  c = uop_count(s[0]);
  d = '0;
  for (int l = 0; l < num_de_uop; l++) begin
    if (l < c) begin
      d[l] = s[0].uop[l];
    end else if (s[1].uop_valid[l-c]) begin
      d[l] = s[1].uop[l-c];
    end
  end
  return d;
endfunction

// final uop of the slot's instruction goes out this cycle
function automatic logic last_fit(de_slot_t [num_de_inst-1:0] s, int slot);
  int c;
  logic found;
  c = uop_count(s[0]);
  found = 1'b0;
  if (slot == 0) begin
    if (c == num_de_uop) begin
      found = s[0].uop[num_de_uop-1].last_uop_valid;
    end else begin
      found = (c > 0);
    end
  end else if (c < num_de_uop) begin
    for (int u = 0; u < num_de_uop - c; u++) begin
      found |= s[1].uop_valid[u] & s[1].uop[u].last_uop_valid;
    end
  end
  return found;
endfunction

// uop to restart from when the slot stays in the command queue
function automatic logic [uop_index_width-1:0] resume_index(
  de_slot_t [num_de_inst-1:0] s, int slot);
  int c;
  c = uop_count(s[0]);
  if (slot == 0) begin
    return s[0].uop[num_de_uop-1].uop_index + uop_index_width'(1);
  end
  if (c == num_de_uop) begin
    return '0;
  end
  return s[1].uop[num_de_uop-1-c].uop_index + uop_index_width'(1);
endfunction

function automatic logic queue_ready(de_slot_t [num_de_inst-1:0] s,
                                     logic [num_de_uop-1:0] af);
  logic [num_de_uop-1:0] mv;
  mv = packed_valid(s);
  return (mv != '0) && ((mv & af) == '0);
endfunction

function automatic logic [num_de_uop-1:0] expected_push(de_slot_t [num_de_inst-1:0] s,
                                                        logic [num_de_uop-1:0] af);
  return packed_valid(s) & {num_de_uop{queue_ready(s, af)}};
endfunction

// pop chain for a given queue readiness
function automatic logic [num_de_inst-1:0] pops_with(de_slot_t [num_de_inst-1:0] s,
                                                     logic rdy);
  logic [num_de_inst-1:0] p;
  p[0] = s[0].pkg_valid && (uop_count(s[0]) == 0 || (last_fit(s, 0) && rdy));
  p[1] = p[0] && s[1].pkg_valid && (uop_count(s[1]) == 0 || (last_fit(s, 1) && rdy));
  return p;
endfunction

function automatic logic resume_load(de_slot_t [num_de_inst-1:0] s,
                                     logic [num_de_uop-1:0] af, int slot);
  logic go;
  logic [num_de_inst-1:0] p;
  go = s[slot].pkg_valid && uop_count(s[slot]) != 0 && !last_fit(s, slot) &&
       queue_ready(s, af);
  if (slot == 1) begin
    p = pops_with(s, queue_ready(s, af));
    go = go && p[0];
  end
  return go;
endfunction

function automatic logic index_clears(de_slot_t [num_de_inst-1:0] s,
                                      logic [num_de_uop-1:0] af);
  logic [num_de_inst-1:0] p;
  p = pops_with(s, queue_ready(s, af));
  return (p[0] && !s[1].pkg_valid) || p[1];
endfunction

// resume register value after the next edge
function automatic logic [uop_index_width-1:0] next_remain(
  de_slot_t [num_de_inst-1:0] s, logic [num_de_uop-1:0] af,
  logic [uop_index_width-1:0] cur);
  if (index_clears(s, af)) begin
    return '0;
  end
  if (resume_load(s, af, 0)) begin
    return resume_index(s, 0);
  end
  if (resume_load(s, af, 1)) begin
    return resume_index(s, 1);
  end
  return cur;
endfunction

`endif

// File: testbench/decode_ctrl_tb.sv
`timescale 1ns/100ps

module decode_ctrl_tb;

  import decode_ctrl_pkg::*;

  `include "decode_ctrl_model.svh"

  logic                       clk;
  logic                       arst_n;
  de_slot_t [num_de_inst-1:0] slots;
  logic [num_de_uop-1:0]      almost_full;
  logic [num_de_inst-1:0]     pop;
  logic [num_de_uop-1:0]      push;
  uop_t [num_de_uop-1:0]      dataout;
  logic [uop_index_width-1:0] uop_index_remain;

  logic [uop_index_width-1:0] exp_remain;
  int seed;
  int err_count;
  int test_count;
  int hit_idle;
  int hit_stall;
  int hit_load0;
  int hit_load1;
  int hit_clear;
  int hit_empty_pop;
  int hit_lane3_last;

  decode_ctrl UUT (
    .clk              (clk),
    .arst_n           (arst_n),
    .slots            (slots),
    .almost_full      (almost_full),
    .pop              (pop),
    .push             (push),
    .dataout          (dataout),
    .uop_index_remain (uop_index_remain)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // expected resume register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_remain <= '0;
    end else begin
      exp_remain <= next_remain(slots, almost_full, exp_remain);
    end
  end

  a_idle_quiet : assert property (@(posedge clk) disable iff (!arst_n)
    (!slots[0].pkg_valid && !slots[1].pkg_valid) |-> (push == '0 && pop == '0)
  ) else begin
    err_count++;
    $display("[ERROR] push = 0x%0h pop = 0x%0h while idle", $sampled(push), $sampled(pop));
  end

  a_dataout : assert property (@(posedge clk) disable iff (!arst_n)
    dataout == packed_data(slots)
  ) else begin
    err_count++;
    $display("[ERROR] dataout = 0x%0h, expected 0x%0h",
             $sampled(dataout), packed_data($sampled(slots)));
  end

  a_push : assert property (@(posedge clk) disable iff (!arst_n)
    push == expected_push(slots, almost_full)
  ) else begin
    err_count++;
    $display("[ERROR] push = 0x%0h, expected 0x%0h",
             $sampled(push), expected_push($sampled(slots), $sampled(almost_full)));
  end

  // back-pressure leaves only pops of empty slots
  a_stall : assert property (@(posedge clk) disable iff (!arst_n)
    ((packed_valid(slots) & almost_full) != '0) |->
      (push == '0 && pop == pops_with(slots, 1'b0))
  ) else begin
    err_count++;
    $display("[ERROR] push = 0x%0h pop = 0x%0h under almost_full = 0x%0h",
             $sampled(push), $sampled(pop), $sampled(almost_full));
  end

  a_pop : assert property (@(posedge clk) disable iff (!arst_n)
    pop == pops_with(slots, queue_ready(slots, almost_full))
  ) else begin
    err_count++;
    $display("[ERROR] pop = 0x%0h, expected 0x%0h", $sampled(pop),
             pops_with($sampled(slots), queue_ready($sampled(slots), $sampled(almost_full))));
  end

  a_remain : assert property (@(posedge clk) disable iff (!arst_n)
    uop_index_remain == exp_remain
  ) else begin
    err_count++;
    $display("[ERROR] uop_index_remain = 0x%0h, expected 0x%0h",
             $sampled(uop_index_remain), $sampled(exp_remain));
  end

  // the last flag sits on a random valid uop or on none
  task automatic build_slot(input int count, input logic valid, output de_slot_t s);
    logic [31:0] rnd;
    int pos;
    s = '0;
    s.pkg_valid = valid;
    if (valid) begin
      for (int i = 0; i < count; i++) begin
        rnd = $random(seed);
        s.uop_valid[i] = 1'b1;
        s.uop[i].uop_index = rnd[uop_index_width-1:0];
        s.uop[i].payload = $random(seed);
      end
      pos = $unsigned($random(seed)) % (count + 1);
      if (pos < count) begin
        s.uop[pos].last_uop_valid = 1'b1;
      end
    end
    // stale payload above the valid uops
    for (int i = 0; i < num_de_uop; i++) begin
      if (!s.uop_valid[i]) begin
        s.uop[i].payload = $random(seed);
      end
    end
  endtask

  task automatic count_hits(input de_slot_t [num_de_inst-1:0] s,
                            input logic [num_de_uop-1:0] af);
    if (!s[0].pkg_valid && !s[1].pkg_valid) hit_idle++;
    if ((packed_valid(s) & af) != '0) hit_stall++;
    if (resume_load(s, af, 0)) hit_load0++;
    if (resume_load(s, af, 1)) hit_load1++;
    if (index_clears(s, af)) hit_clear++;
    if (s[0].pkg_valid && uop_count(s[0]) == 0) hit_empty_pop++;
    if (uop_count(s[0]) == num_de_uop && last_fit(s, 0) && queue_ready(s, af)) begin
      hit_lane3_last++;
    end
  endtask

  task automatic drive_cycle(input de_slot_t [num_de_inst-1:0] s,
                             input logic [num_de_uop-1:0] af);
    @(posedge clk);
    #10;
    slots = s;
    almost_full = af;
    count_hits(s, af);
  endtask

  task automatic random_cycle(input logic force_stall);
    de_slot_t [num_de_inst-1:0] s;
    de_slot_t one;
    logic [31:0] rnd;
    logic [num_de_uop-1:0] mv;
    logic [num_de_uop-1:0] af;
    logic pv0;
    logic pv1;
    rnd = $random(seed);
    pv0 = (rnd[2:0] != 3'd0);
    pv1 = pv0 && (rnd[4:3] != 2'd0);
    build_slot($unsigned($random(seed)) % (num_de_uop + 1), pv0, one);
    s[0] = one;
    build_slot($unsigned($random(seed)) % (num_de_uop + 1), pv1, one);
    s[1] = one;
    mv = packed_valid(s);
    rnd = $random(seed);
    af = '0;
    if (force_stall) begin
      // lowest used lane always full
      af = rnd[num_de_uop-1:0] | (mv & (~mv + num_de_uop'(1)));
    end else if (rnd[7:4] == 4'd0) begin
      af = rnd[num_de_uop-1:0];
    end
    drive_cycle(s, af);
  endtask

  task automatic finish_test(input string name, input int cycles, input int errs_before);
    @(posedge clk);
    #10;
    test_count++;
    $display("test %s done: %0d cycles, %0d errors", name, cycles, err_count - errs_before);
  endtask

  function automatic logic all_hit();
    return hit_idle >= 2 && hit_stall >= 2 && hit_load0 >= 2 && hit_load1 >= 2 &&
           hit_clear >= 2 && hit_empty_pop >= 2 && hit_lane3_last >= 2;
  endfunction

  initial begin
    de_slot_t [num_de_inst-1:0] s;
    de_slot_t one;
    int cycles;
    int errs_before;
    logic timed_out;
    seed = 26560;
    err_count = 0;
    test_count = 0;
    hit_idle = 0;
    hit_stall = 0;
    hit_load0 = 0;
    hit_load1 = 0;
    hit_clear = 0;
    hit_empty_pop = 0;
    hit_lane3_last = 0;
    timed_out = 1'b0;
    slots = '0;
    almost_full = '0;
    arst_n = 1'b0;

    errs_before = err_count;
    repeat (2) @(posedge clk);
    #10;
    arst_n = 1'b1;
    a_reset_zero : assert (uop_index_remain == '0) else begin
      err_count++;
      $display("[ERROR] uop_index_remain = 0x%0h after reset", uop_index_remain);
    end
    for (cycles = 0; cycles < 4; cycles++) begin
      drive_cycle('0, '0);
    end
    finish_test("reset_idle", cycles, errs_before);

    // every pair of occupancies with room in all lanes
    errs_before = err_count;
    cycles = 0;
    for (int c0 = 0; c0 <= num_de_uop; c0++) begin
      for (int c1 = 0; c1 <= num_de_uop; c1++) begin
        build_slot(c0, 1'b1, one);
        s[0] = one;
        build_slot(c1, 1'b1, one);
        s[1] = one;
        drive_cycle(s, '0);
        cycles++;
      end
    end
    finish_test("occupancy_sweep", cycles, errs_before);

    errs_before = err_count;
    for (cycles = 0; cycles < 40; cycles++) begin
      random_cycle(1'b1);
    end
    finish_test("back_pressure", cycles, errs_before);

    errs_before = err_count;
    cycles = 0;
    while (!all_hit() && cycles < 4000) begin
      random_cycle(1'b0);
      cycles++;
    end
    if (!all_hit()) begin
      timed_out = 1'b1;
      $display("timeout: random stimulus did not reach every behavior in %0d cycles", cycles);
    end
    finish_test("random", cycles, errs_before);

    $display("summary: %0d tests, %0d errors", test_count, err_count);
    if (err_count == 0 && !timed_out) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
